//--- src/vmem_addr_sched.sv
`timescale 1ns/1ns

module vmem_addr_sched (
  input  logic              CLK,
  input  logic              nRST,
  input  vmem_pkg::ex_mem_t ex,
  input  logic              dhit,
  input  logic              stall,
  output vmem_pkg::dreq_t   dreq,
  output logic              arrived0,
  output logic              arrived1,
  output logic [1:0]        lane_off0,
  output logic [1:0]        lane_off1,
  output logic              busy,
  output logic              advance,
  output logic              exception
);
  import vmem_pkg::*;

  typedef enum logic [1:0] {IDLE, LANE0, LANE1, DONE} state_t;

  state_t          state, next_state;
  logic            is_mem, lane1_run, misaligned, in_lane;
  logic [XLEN-1:0] cur_addr, cur_data;
  logic [1:0]      cur_off;
  logic [3:0]      cur_bena;

  // Address low bits that break natural alignment for this width
  function automatic logic addr_bad(eew_t e, logic [1:0] low);
    case (e)
      E16:     addr_bad = low[0];
      E32:     addr_bad = |low;
      default: addr_bad = 1'b0;
    endcase
  endfunction

  assign is_mem     = ex.load_ena | ex.store_ena;
  // Lane 1 only while the next element is still inside vl
  assign lane1_run  = ({1'b0, ex.ls_idx} + (VL_W+1)'(1)) < {1'b0, ex.vl};
  assign misaligned = addr_bad(ex.eew, ex.alu_result0[1:0]) ||
                      (lane1_run && addr_bad(ex.eew, ex.alu_result1[1:0]));

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (is_mem) next_state = misaligned ? DONE : LANE0;
      LANE0:   if (dhit) next_state = lane1_run ? LANE1 : DONE;
      LANE1:   if (dhit) next_state = DONE;
      DONE:    if (!stall) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      lane_off0 <= '0;
      lane_off1 <= '0;
    end else begin
      state <= next_state;
      // Offsets stay valid until the bundle leaves the stage
      if (state == IDLE && is_mem) begin
        lane_off0 <= ex.alu_result0[1:0];
        lane_off1 <= ex.alu_result1[1:0];
      end
    end
  end

  // Current lane request
  assign in_lane  = (state == LANE0) || (state == LANE1);
  assign cur_addr = (state == LANE1) ? ex.alu_result1 : ex.alu_result0;
  assign cur_data = (state == LANE1) ? ex.store_data1 : ex.store_data0;
  assign cur_off  = cur_addr[1:0];

  always_comb begin
    case (ex.eew)
      E8:      cur_bena = 4'b0001 << cur_off;
      E16:     cur_bena = 4'b0011 << cur_off;
      default: cur_bena = 4'b1111;
    endcase
  end

  always_comb begin
    dreq.ren        = in_lane && ex.load_ena;
    dreq.wen        = in_lane && ex.store_ena;
    dreq.addr       = {cur_addr[XLEN-1:2], 2'b00};
    dreq.byte_ena   = cur_bena;
    dreq.store_data = cur_data << {cur_off, 3'b000};
  end

  assign arrived0  = (state == LANE0) && dhit;
  assign arrived1  = (state == LANE1) && dhit;
  assign busy      = (state == IDLE && is_mem) || in_lane;
  // Non-memory bundles pass straight through from IDLE
  assign advance   = !stall && ((state == IDLE && !is_mem) || state == DONE);
  assign exception = (state == IDLE) && is_mem && misaligned;

  // A pending request must not move before the cache answers
  a_dreq_hold: assert property (@(posedge CLK) disable iff (!nRST)
    ((dreq.ren || dreq.wen) && !dhit) |=> $stable(dreq));

  // Execute side never asks for load and store at once
  a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
    !(dreq.ren && dreq.wen));

endmodule

//--- src/vmem_load_align.sv
`timescale 1ns/1ns

module vmem_load_align (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vmem_pkg::ex_mem_t         ex,
  input  logic [vmem_pkg::XLEN-1:0] rdata,
  input  logic                      arrived0,
  input  logic                      arrived1,
  input  logic [1:0]                lane_off0,
  input  logic [1:0]                lane_off1,
  input  logic                      exception,
  output logic [vmem_pkg::XLEN-1:0] wdat0,
  output logic [vmem_pkg::XLEN-1:0] wdat1
);
  import vmem_pkg::*;

  logic [XLEN-1:0] load_buf0, load_buf1;
  logic [XLEN-1:0] shifted0, shifted1;
  logic [XLEN-1:0] width_mask;

  // One buffered word per lane
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      load_buf0 <= '0;
      load_buf1 <= '0;
    end else if (exception) begin
      // Misaligned pair completes with zero data
      load_buf0 <= '0;
      load_buf1 <= '0;
    end else begin
      if (arrived0) begin
        load_buf0 <= rdata;
      end
      if (arrived1) begin
        load_buf1 <= rdata;
      end
    end
  end

  always_comb begin
    case (ex.eew)
      E8:      width_mask = 32'h0000_00ff;
      E16:     width_mask = 32'h0000_ffff;
      default: width_mask = '1;
    endcase
  end

  // Bring the element down to bit 0
  assign shifted0 = load_buf0 >> {lane_off0, 3'b000};
  assign shifted1 = load_buf1 >> {lane_off1, 3'b000};

  assign wdat0 = ex.load_ena ? (shifted0 & width_mask) : ex.alu_result0;
  assign wdat1 = ex.load_ena ? (shifted1 & width_mask) : ex.alu_result1;

endmodule

//--- src/vmem_pkg.sv
package vmem_pkg;

  localparam int XLEN  = 32;
  localparam int VLENB = 16;
  localparam int VL_W  = 5;

  // Element width of a vector memory access
  typedef enum logic [1:0] {
    E8  = 2'd0,
    E16 = 2'd1,
    E32 = 2'd2
  } eew_t;

  typedef enum logic {
    NOT_CFG = 1'b0,
    VSETVL  = 1'b1
  } cfg_t;

  typedef struct packed {
    logic [2:0] reserved;
    logic [2:0] lmul;
    eew_t       sew;
  } vtype_t;

  // Execute to memory bundle
  typedef struct packed {
    logic [XLEN-1:0] alu_result0;
    logic [XLEN-1:0] alu_result1;
    logic [XLEN-1:0] store_data0;
    logic [XLEN-1:0] store_data1;
    logic            load_ena;
    logic            store_ena;
    eew_t            eew;
    logic [VL_W-1:0] ls_idx;
    logic [VL_W-1:0] vl;
    logic [1:0]      wen;
    logic [VL_W-1:0] woffset0;
    logic [VL_W-1:0] woffset1;
    logic [4:0]      vd;
    logic            rd_wen;
    logic [4:0]      rd_sel;
    logic [XLEN-1:0] rd_data;
    cfg_t            config_type;
    vtype_t          next_vtype;
    logic [XLEN-1:0] next_avl;
  } ex_mem_t;

  // Memory to writeback bundle
  typedef struct packed {
    logic [XLEN-1:0] wdat0;
    logic [XLEN-1:0] wdat1;
    logic [1:0]      wen;
    logic [VL_W-1:0] woffset0;
    logic [VL_W-1:0] woffset1;
    logic [4:0]      vd;
    eew_t            eew;
    logic [VL_W-1:0] vl;
    logic            rd_wen;
    logic [4:0]      rd_sel;
    logic [XLEN-1:0] rd_data;
  } mem_wb_t;

  // Single word request to the data cache
  typedef struct packed {
    logic            ren;
    logic            wen;
    logic [XLEN-1:0] addr;
    logic [3:0]      byte_ena;
    logic [XLEN-1:0] store_data;
  } dreq_t;

  // Elements that fit in one vector register at this width
  function automatic logic [VL_W-1:0] vlmax(eew_t sew);
    int ebytes;
    case (sew)
      E8:      ebytes = 1;
      E16:     ebytes = 2;
      default: ebytes = 4;
    endcase
    return VL_W'(VLENB / ebytes);
  endfunction

endpackage

//--- src/vmem_stage.sv
`timescale 1ns/1ns

module vmem_stage (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vmem_pkg::ex_mem_t         ex,
  input  logic                      stall,
  input  logic                      flush,
  input  logic                      dhit,
  input  logic [vmem_pkg::XLEN-1:0] rdata,
  output vmem_pkg::dreq_t           dreq,
  output logic                      busy,
  output logic                      exception,
  output vmem_pkg::mem_wb_t         wb,
  output logic [vmem_pkg::VL_W-1:0] vl_csr,
  output vmem_pkg::vtype_t          vtype_csr
);
  import vmem_pkg::*;

  logic            arrived0, arrived1;
  logic [1:0]      lane_off0, lane_off1;
  logic            advance;
  logic [XLEN-1:0] wdat0, wdat1;

  vmem_addr_sched u_sched (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex        (ex),
    .dhit      (dhit),
    .stall     (stall),
    .dreq      (dreq),
    .arrived0  (arrived0),
    .arrived1  (arrived1),
    .lane_off0 (lane_off0),
    .lane_off1 (lane_off1),
    .busy      (busy),
    .advance   (advance),
    .exception (exception)
  );

  vmem_load_align u_align (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex        (ex),
    .rdata     (rdata),
    .arrived0  (arrived0),
    .arrived1  (arrived1),
    .lane_off0 (lane_off0),
    .lane_off1 (lane_off1),
    .exception (exception),
    .wdat0     (wdat0),
    .wdat1     (wdat1)
  );

  vmem_wb_latch u_latch (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex        (ex),
    .wdat0     (wdat0),
    .wdat1     (wdat1),
    .advance   (advance),
    .flush     (flush),
    .wb        (wb),
    .vl_csr    (vl_csr),
    .vtype_csr (vtype_csr)
  );

endmodule

//--- src/vmem_wb_latch.sv
`timescale 1ns/1ns

module vmem_wb_latch (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vmem_pkg::ex_mem_t         ex,
  input  logic [vmem_pkg::XLEN-1:0] wdat0,
  input  logic [vmem_pkg::XLEN-1:0] wdat1,
  input  logic                      advance,
  input  logic                      flush,
  output vmem_pkg::mem_wb_t         wb,
  output logic [vmem_pkg::VL_W-1:0] vl_csr,
  output vmem_pkg::vtype_t          vtype_csr
);
  import vmem_pkg::*;

  mem_wb_t         next_wb;
  logic [VL_W-1:0] cfg_max, new_vl;
  logic            is_cfg;

  assign is_cfg  = (ex.config_type == VSETVL);
  assign cfg_max = vlmax(ex.next_vtype.sew);
  // Requested length clipped to what the new type allows
  assign new_vl  = (ex.next_avl < XLEN'(cfg_max)) ? ex.next_avl[VL_W-1:0] : cfg_max;

  always_comb begin
    next_wb.wdat0    = wdat0;
    next_wb.wdat1    = wdat1;
    next_wb.wen      = ex.wen;
    next_wb.woffset0 = ex.woffset0;
    next_wb.woffset1 = ex.woffset1;
    next_wb.vd       = ex.vd;
    next_wb.eew      = ex.eew;
    next_wb.vl       = ex.vl;
    next_wb.rd_wen   = ex.rd_wen;
    next_wb.rd_sel   = ex.rd_sel;
    // Config instructions return the granted vl
    next_wb.rd_data  = is_cfg ? XLEN'(new_vl) : ex.rd_data;
  end

  // Memory to writeback register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb <= '0;
    end else if (flush) begin
      wb <= '0;
    end else if (advance) begin
      wb <= next_wb;
    end
  end

  // vl and vtype registers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl_csr    <= '0;
      vtype_csr <= '0;
    end else if (advance && !flush && is_cfg) begin
      vl_csr    <= new_vl;
      vtype_csr <= ex.next_vtype;
    end
  end

  // Flushed slot carries no register writes
  a_flush_clears: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> (wb.wen == 2'b00) && !wb.rd_wen);

endmodule

//--- tests/dcache_model.sv
`timescale 1ns/1ns

// Word addressed data memory that answers each request two cycles after it appears
module dcache_model (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vmem_pkg::dreq_t           dreq,
  output logic                      dhit,
  output logic [vmem_pkg::XLEN-1:0] rdata
);
  import vmem_pkg::*;

  logic [XLEN-1:0] mem [64];
  logic            wait_cnt;
  logic [5:0]      idx;

  assign idx = dreq.addr[7:2];

  function automatic logic [XLEN-1:0] merge_bytes(logic [XLEN-1:0] old_word,
                                                  logic [XLEN-1:0] new_word,
                                                  logic [3:0] be);
    logic [XLEN-1:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= 1'b0;
      dhit     <= 1'b0;
      rdata    <= '0;
    end else begin
      dhit <= 1'b0;
      // The dhit cycle itself does not count towards the next request
      if ((dreq.ren || dreq.wen) && !dhit) begin
        if (wait_cnt) begin
          wait_cnt <= 1'b0;
          dhit     <= 1'b1;
          rdata    <= mem[idx];
          if (dreq.wen) begin
            mem[idx] <= merge_bytes(mem[idx], dreq.store_data, dreq.byte_ena);
          end
        end else begin
          wait_cnt <= 1'b1;
        end
      end
    end
  end

endmodule

//--- tests/tb_vmem_stage.sv
`timescale 1ns/1ns

module tb_vmem_stage;
  import vmem_pkg::*;

  logic            CLK, nRST, stall, flush, dhit, busy, exception;
  logic [XLEN-1:0] rdata;
  ex_mem_t         ex;
  dreq_t           dreq;
  mem_wb_t         wb;
  logic [VL_W-1:0] vl_csr;
  vtype_t          vtype_csr;

  logic [XLEN-1:0] shadow [64];
  int              checks, errors, test_start, reads, req_cycles, exc_pulses, lat;

  vmem_stage u_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex        (ex),
    .stall     (stall),
    .flush     (flush),
    .dhit      (dhit),
    .rdata     (rdata),
    .dreq      (dreq),
    .busy      (busy),
    .exception (exception),
    .wb        (wb),
    .vl_csr    (vl_csr),
    .vtype_csr (vtype_csr)
  );

  dcache_model u_cache (
    .CLK   (CLK),
    .nRST  (nRST),
    .dreq  (dreq),
    .dhit  (dhit),
    .rdata (rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Cache traffic and exceptions of the current bundle
  always @(posedge CLK) begin
    if (dreq.ren || dreq.wen) req_cycles++;
    if (dhit && dreq.ren) reads++;
    if (exception) exc_pulses++;
  end

  function automatic int elem_bytes(eew_t e);
    case (e)
      E8:      return 1;
      E16:     return 2;
      default: return 4;
    endcase
  endfunction

  // Element at a byte offset of a memory word, zero extended
  function automatic logic [XLEN-1:0] expect_load(logic [XLEN-1:0] word, eew_t e, int off);
    logic [XLEN-1:0] mask;
    mask = (elem_bytes(e) == 4) ? '1 : ((XLEN'(1) << (8 * elem_bytes(e))) - 1);
    return (word >> (8 * off)) & mask;
  endfunction

  task automatic shadow_store(logic [XLEN-1:0] addr, logic [XLEN-1:0] data, eew_t e);
    int off;
    off = addr[1:0];
    for (int i = 0; i < elem_bytes(e); i++) begin
      shadow[addr[7:2]][8*(off+i) +: 8] = data[8*i +: 8];
    end
  endtask

  function automatic ex_mem_t mem_bundle(bit is_load, eew_t e, logic [XLEN-1:0] a0,
                                         logic [XLEN-1:0] a1, logic [VL_W-1:0] vl);
    ex_mem_t b;
    b             = '0;
    b.load_ena    = is_load;
    b.store_ena   = !is_load;
    b.eew         = e;
    b.alu_result0 = a0;
    b.alu_result1 = a1;
    b.vl          = vl;
    b.store_data0 = $urandom;
    b.store_data1 = $urandom;
    b.wen         = is_load ? 2'b11 : 2'b00;
    b.vd          = 5'd3;
    return b;
  endfunction

  task automatic check_eq(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic present(ex_mem_t b);
    ex         = b;
    reads      = 0;
    req_cycles = 0;
    exc_pulses = 0;
  endtask

  // Wait for the edge that loads wb and return to an idle bundle
  task automatic wait_wb();
    bit done;
    done = 1'b0;
    lat  = 0;
    while (!done && lat < 200) begin
      #1;
      done = !busy && !stall;
      @(posedge CLK);
      #1;
      lat++;
    end
    ex = '0;
    if (!done) begin
      errors++;
      $display("ERROR: writeback register not updated within 200 cycles");
    end
  endtask

  task automatic issue(ex_mem_t b);
    present(b);
    wait_wb();
  endtask

  task automatic finish_test(string name);
    $display("test %s: %0d error(s)", name, errors - test_start);
    test_start = errors;
  endtask

  task automatic test_reset_alu();
    ex_mem_t b;
    check_eq("wb.wen", wb.wen, 0);
    check_eq("wb.rd_wen", wb.rd_wen, 0);
    check_eq("vl_csr", vl_csr, 0);
    b             = '0;
    b.alu_result0 = $urandom;
    b.alu_result1 = $urandom;
    b.wen         = 2'b01;
    b.woffset0    = 5'd3;
    b.woffset1    = 5'd12;
    b.eew         = E16;
    b.vd          = 5'd7;
    b.vl          = 5'd4;
    b.rd_wen      = 1'b1;
    b.rd_sel      = 5'd9;
    b.rd_data     = $urandom;
    issue(b);
    check_eq("latency", lat, 1);
    check_eq("wb.wdat0", wb.wdat0, b.alu_result0);
    check_eq("wb.wdat1", wb.wdat1, b.alu_result1);
    check_eq("wb.wen", wb.wen, b.wen);
    check_eq("wb.woffset0", wb.woffset0, b.woffset0);
    check_eq("wb.woffset1", wb.woffset1, b.woffset1);
    check_eq("wb.eew", wb.eew, b.eew);
    check_eq("wb.vd", wb.vd, b.vd);
    check_eq("wb.vl", wb.vl, b.vl);
    check_eq("wb.rd_wen", wb.rd_wen, b.rd_wen);
    check_eq("wb.rd_sel", wb.rd_sel, b.rd_sel);
    check_eq("wb.rd_data", wb.rd_data, b.rd_data);
    finish_test("reset_alu");
  endtask

  task automatic test_loads();
    eew_t    e;
    int      w0, w1;
    for (int k = 0; k < 3; k++) begin
      e = eew_t'(k);
      for (int off = 0; off < 4; off += elem_bytes(e)) begin
        w0 = k * 4 + off;
        w1 = 32 + k * 4 + off;
        issue(mem_bundle(1'b1, e, 4 * w0 + off, 4 * w1 + off, 5'd2));
        check_eq("wb.wdat0", wb.wdat0, expect_load(shadow[w0], e, off));
        check_eq("wb.wdat1", wb.wdat1, expect_load(shadow[w1], e, off));
        check_eq("reads", reads, 2);
      end
    end
    // Last element of vl leaves lane 1 quiet
    issue(mem_bundle(1'b1, E32, 32'h10, 32'h14, 5'd1));
    check_eq("wb.wdat0", wb.wdat0, shadow[4]);
    check_eq("reads", reads, 1);
    finish_test("loads");
  endtask

  task automatic test_stores();
    ex_mem_t b;
    b = mem_bundle(1'b0, E8, 32'h61, 32'h66, 5'd2);
    issue(b);
    shadow_store(32'h61, b.store_data0, E8);
    shadow_store(32'h66, b.store_data1, E8);
    b = mem_bundle(1'b0, E16, 32'h6a, 32'h6c, 5'd2);
    issue(b);
    shadow_store(32'h6a, b.store_data0, E16);
    shadow_store(32'h6c, b.store_data1, E16);
    for (int w = 24; w < 28; w += 2) begin
      issue(mem_bundle(1'b1, E32, 4 * w, 4 * (w + 1), 5'd2));
      check_eq("wb.wdat0", wb.wdat0, shadow[w]);
      check_eq("wb.wdat1", wb.wdat1, shadow[w+1]);
    end
    finish_test("stores");
  endtask

  task automatic test_misaligned();
    issue(mem_bundle(1'b1, E32, 32'h21, 32'h24, 5'd2));
    check_eq("exception pulses", exc_pulses, 1);
    check_eq("dreq cycles", req_cycles, 0);
    check_eq("wb.wdat0", wb.wdat0, 0);
    check_eq("wb.wdat1", wb.wdat1, 0);
    finish_test("misaligned");
  endtask

  task automatic test_stall_flush();
    ex_mem_t b;
    mem_wb_t saved;
    stall = 1'b1;
    present(mem_bundle(1'b1, E32, 32'h30, 32'h34, 5'd2));
    saved = wb;
    repeat (12) begin
      @(posedge CLK);
      #1;
      checks++;
      if (wb !== saved) begin
        errors++;
        $display("MISMATCH wb got=%h exp=%h", wb, saved);
      end
    end
    stall = 1'b0;
    wait_wb();
    check_eq("wb.wdat0", wb.wdat0, shadow[12]);
    check_eq("wb.wdat1", wb.wdat1, shadow[13]);
    // Flush wins over an advancing bundle
    b             = '0;
    b.wen         = 2'b11;
    b.rd_wen      = 1'b1;
    b.rd_sel      = 5'd5;
    b.alu_result0 = $urandom;
    ex            = b;
    flush         = 1'b1;
    @(posedge CLK);
    #1;
    flush = 1'b0;
    ex    = '0;
    check_eq("wb.wen", wb.wen, 0);
    check_eq("wb.rd_wen", wb.rd_wen, 0);
    finish_test("stall_flush");
  endtask

  task automatic test_config();
    ex_mem_t b;
    int      avls [5] = '{3, 10, 20, 8, 100};
    eew_t    sews [5] = '{E32, E32, E8, E16, E16};
    int      max_vl, exp_vl;
    for (int i = 0; i < 5; i++) begin
      b                 = '0;
      b.config_type     = VSETVL;
      b.next_vtype.sew  = sews[i];
      b.next_vtype.lmul = 3'(i);
      b.next_avl        = avls[i];
      b.rd_wen          = 1'b1;
      b.rd_sel          = 5'd10;
      issue(b);
      max_vl = VLENB / elem_bytes(sews[i]);
      exp_vl = (avls[i] < max_vl) ? avls[i] : max_vl;
      check_eq("vl_csr", vl_csr, exp_vl);
      check_eq("vtype_csr", vtype_csr, b.next_vtype);
      check_eq("wb.rd_data", wb.rd_data, exp_vl);
    end
    finish_test("config");
  endtask

  initial begin
    void'($urandom(81));
    nRST       = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    ex         = '0;
    checks     = 0;
    errors     = 0;
    test_start = 0;
    for (int i = 0; i < 64; i++) begin
      shadow[i]      = $urandom;
      u_cache.mem[i] = shadow[i];
    end
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    test_reset_alu();
    test_loads();
    test_stores();
    test_misaligned();
    test_stall_flush();
    test_config();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/vmem_pkg.sv
src/vmem_addr_sched.sv
src/vmem_load_align.sv
src/vmem_wb_latch.sv
src/vmem_stage.sv
tests/dcache_model.sv
tests/tb_vmem_stage.sv
